// ==== Makefile ====
# verilator build and run of the fp_pe testbench
TOP := fp_pe_tb

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): tb.f source/*.sv source/*.svh sim/*.sv
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f tb.f

# exit status of the simulator is the test result
run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP)

lint:
	verilator --lint-only -Wall --timing --assert --top-module $(TOP) -f tb.f

clean:
	rm -rf obj_dir

// ==== sim/fp_pe_assert.sv ====
`timescale 1ns/1ps
`include "fp_pe_config.svh"

module fp_pe_assert (
    input logic              i_clk,
    input logic              i_rst,
    input logic              i_valid1,
    input logic              i_valid2,
    input fp_pe_pkg::pe_op_e i_op,
    input logic              i_out_valid,  // dut o_valid
    input logic              i_out_last    // dut o_last
);
    import fp_pe_pkg::*;

    logic       item_ok;     // valid rule for the item at the inputs
    logic [3:0] settle_cnt;  // edges since reset, stops at the latency

    assign item_ok = ((i_op == OP_ADD) || (i_op == OP_MUL) || (i_op == OP_MACC))
                     ? (i_valid1 && i_valid2) : i_valid1;

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            settle_cnt <= '0;
        end else if (settle_cnt < 4'(`FP_PE_LAT)) begin
            settle_cnt <= settle_cnt + 4'd1;
        end
    end

    a_reset_clears: assert property (@(posedge i_clk) i_rst |=> (!i_out_valid && !i_out_last))
        else $error("o_valid or o_last high in the cycle after reset");

    a_last_gated: assert property (@(posedge i_clk) disable iff (i_rst)
        i_out_last |-> i_out_valid)
        else $error("o_last high without o_valid");

    // valid comes out one pipeline latency after the item
    a_valid_latency: assert property (@(posedge i_clk) disable iff (i_rst)
        (settle_cnt == 4'(`FP_PE_LAT)) |-> (i_out_valid == $past(item_ok, `FP_PE_LAT)))
        else $error("o_valid does not follow the valid rule of its item");

endmodule

bind fp_pe fp_pe_assert u_fp_pe_assert (
    .i_clk       (i_clk),
    .i_rst       (i_rst),
    .i_valid1    (i_valid1),
    .i_valid2    (i_valid2),
    .i_op        (i_op),
    .i_out_valid (o_valid),
    .i_out_last  (o_last)
);

// ==== sim/fp_pe_tb.sv ====
`timescale 1ns/1ps
`include "fp_pe_config.svh"

module fp_pe_tb;
    import fp_pe_pkg::*;

    localparam int LAT            = `FP_PE_LAT;
    localparam int N_ADD          = 10;
    localparam int N_MUL          = 10;
    localparam int N_MACC         = 12;
    localparam int N_MIXED        = 200;
    localparam int TIMEOUT_CYCLES = 2 * (N_ADD + N_MUL + N_MACC + N_MIXED + 5 * LAT + 10);

    logic        clk;
    logic        rst;
    fp_word_t    inp1;
    fp_word_t    inp2;
    fp_word_t    inp3;
    logic        valid1;
    logic        valid2;
    logic        last1;
    logic        last2;
    pe_op_e      op;
    fp_word_t    out_w;
    logic        out_valid;
    logic        out_last;
    int unsigned cyc = 0;                  // rising edges so far
    logic [31:0] lcg_state = 32'h59f9;
    string       cur_test = "reset";
    int unsigned tag_q [$];                // drive cycle of each item
    fp_word_t    word_q [$];
    logic        valid_q [$];
    logic        last_q [$];
    string       name_q [$];

    fp_pe UUT (
        .i_clk    (clk),
        .i_rst    (rst),
        .i_inp1   (inp1),
        .i_inp2   (inp2),
        .i_inp3   (inp3),
        .i_valid1 (valid1),
        .i_valid2 (valid2),
        .i_last1  (last1),
        .i_last2  (last2),
        .i_op     (op),
        .o_out    (out_w),
        .o_valid  (out_valid),
        .o_last   (out_last)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("TEST RESULT: FAIL");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_word(input string name, input fp_word_t exp_w, input fp_word_t act_w);
        if (act_w.raw !== exp_w.raw) begin
            abort_run($sformatf("ERR %s: o_out expected %h actual %h",
                                name, exp_w.raw, act_w.raw));
        end
    endtask

    task automatic check_bit(input string name, input string what,
                             input logic exp_b, input logic act_b);
        if (act_b !== exp_b) begin
            abort_run($sformatf("ERR %s: %s expected %b actual %b", name, what, exp_b, act_b));
        end
    endtask

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // -2048 .. 2047, every sum and product stays exact
    function automatic int rand_small();
        logic [31:0] r;
        r = lcg_next();
        return int'({20'd0, r[27:16]}) - 2048;
    endfunction

    // exact binary32 of an integer below 2**24
    function automatic fp_word_t int_to_fp(input int v);
        fp_word_t    w;
        int unsigned mag;
        int          msb;
        w.raw = '0;
        mag   = (v < 0) ? unsigned'(-v) : unsigned'(v);
        msb   = 0;
        for (int i = 0; i < 24; i++) begin
            if (mag[i]) msb = i;
        end
        if (mag != 0) begin
            w.f.sign = (v < 0);
            w.f.exp  = 8'(127 + msb);
            w.f.man  = 23'(mag << (23 - msb));  // hidden bit falls off the top
        end
        return w;
    endfunction

    // one item on the falling edge, expected result queued
    task automatic drive_item(input string name, input logic [2:0] op_code,
                              input int a, input int b, input int c,
                              input logic v1, input logic v2, input logic l1, input logic l2);
        fp_word_t exp_w;
        logic     exp_v;
        logic     exp_l;
        @(negedge clk);
        inp1   = int_to_fp(a);
        inp2   = int_to_fp(b);
        inp3   = int_to_fp(c);
        op     = pe_op_e'(op_code);
        valid1 = v1;
        valid2 = v2;
        last1  = l1;
        last2  = l2;
        exp_v  = v1 & v2;          // two-operand ops need both
        exp_l  = exp_v & (l1 | l2);
        case (op_code)
            OP_ADD:  exp_w = int_to_fp(a + b);
            OP_MUL:  exp_w = int_to_fp(a * b);
            OP_MACC: exp_w = int_to_fp(a * b + c);
            default: begin         // pass a through
                exp_w = int_to_fp(a);
                exp_v = v1;
                exp_l = v1 & l1;
            end
        endcase
        tag_q.push_back(cyc);
        word_q.push_back(exp_w);
        valid_q.push_back(exp_v);
        last_q.push_back(exp_l);
        name_q.push_back(name);
    endtask

    task automatic drain();
        repeat (LAT + 2) begin
            @(negedge clk);
            valid1 = 1'b0;
            valid2 = 1'b0;
            last1  = 1'b0;
            last2  = 1'b0;
        end
    endtask

    task automatic run_reset_test();
        cur_test = "reset";
        repeat (3) @(posedge clk);  // reset held over three rising edges
        @(negedge clk);
        rst = 1'b0;
        repeat (LAT) begin
            @(negedge clk);
            check_bit(cur_test, "o_valid", 1'b0, out_valid);
            check_bit(cur_test, "o_last", 1'b0, out_last);
        end
    endtask

    task automatic run_add_test();
        int a_v [N_ADD] = '{3, -5, 0, 9, 100, -2048, 1024, -7, 2047, 0};
        int b_v [N_ADD] = '{4, 2, 7, 0, -100, 2048, -3, -8, 1, 0};
        cur_test = "add";
        for (int i = 0; i < N_ADD; i++) begin
            drive_item(cur_test, OP_ADD, a_v[i], b_v[i], 0, 1'b1, 1'b1, 1'b0, (i == N_ADD - 1));
        end
        drain();
    endtask

    task automatic run_mul_test();
        int a_v [N_MUL] = '{3, 0, -6, -3, -12, 256, -1024, 2048, 1, 45};
        int b_v [N_MUL] = '{4, -5, 0, 7, -11, 8, 2048, 2048, -1, 45};
        cur_test = "mul";
        for (int i = 0; i < N_MUL; i++) begin
            drive_item(cur_test, OP_MUL, a_v[i], b_v[i], 0, 1'b1, 1'b1, (i == N_MUL - 1), 1'b0);
        end
        drain();
    endtask

    // back to back, new broadcast c on every item
    task automatic run_macc_test();
        cur_test = "macc";
        drive_item(cur_test, OP_MACC, 3, 4, -12, 1'b1, 1'b1, 1'b0, 1'b0);  // cancels to +0
        for (int i = 1; i < N_MACC; i++) begin
            drive_item(cur_test, OP_MACC, rand_small(), rand_small(), rand_small(),
                       1'b1, 1'b1, 1'b0, (i == N_MACC - 1));
        end
        drain();
    endtask

    task automatic run_mixed_test();
        logic [31:0] r;
        cur_test = "mixed";
        for (int i = 0; i < N_MIXED; i++) begin
            r = lcg_next();
            drive_item(cur_test, r[30:28], rand_small(), rand_small(), rand_small(),
                       r[27] | r[26], r[25] | r[24], r[23] & r[22], r[21] & r[20]);
        end
        drain();
    endtask

    always @(posedge clk) begin
        cyc <= cyc + 1;
        if (cyc >= TIMEOUT_CYCLES) begin
            abort_run("timeout, the run took longer than its cycle limit");
        end
    end

    // results are stable between edges, checked on the falling edge
    always @(negedge clk) begin
        string mon_name;
        if (cyc >= 1) begin
            if ((tag_q.size() != 0) && (tag_q[0] + LAT == cyc)) begin
                mon_name = name_q.pop_front();
                tag_q.delete(0);
                check_bit(mon_name, "o_valid", valid_q[0], out_valid);
                if (valid_q[0]) check_word(mon_name, word_q[0], out_w);
                check_bit(mon_name, "o_last", last_q[0], out_last);
                void'(word_q.pop_front());
                void'(valid_q.pop_front());
                void'(last_q.pop_front());
            end else begin
                check_bit(cur_test, "idle o_valid", 1'b0, out_valid);
                check_bit(cur_test, "idle o_last", 1'b0, out_last);
            end
        end
    end

    initial begin
        rst    = 1'b1;
        inp1   = '0;
        inp2   = '0;
        inp3   = '0;
        valid1 = 1'b0;
        valid2 = 1'b0;
        last1  = 1'b0;
        last2  = 1'b0;
        op     = OP_ADD;
        run_reset_test();
        run_add_test();
        run_mul_test();
        run_macc_test();
        run_mixed_test();
        if (tag_q.size() == 0) begin
            $display("TEST RESULT: PASS");
            $finish;
        end else begin
            abort_run("results still pending after the last test");
        end
    end

endmodule

// ==== source/delay_line.sv ====
`timescale 1ns/1ps

module delay_line #(
    parameter int WIDTH = 1,  // bits carried per stage
    parameter int DEPTH = 1   // cycles of delay, 1 or more
) (
    input  logic             i_clk,
    input  logic             i_rst,
    input  logic [WIDTH-1:0] i_din,
    output logic [WIDTH-1:0] o_dout
);

    logic [WIDTH-1:0] pipe [DEPTH];  // pipe[0] is the newest entry

    // every stage clears, so strobes in the bundle start low
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            for (int i = 0; i < DEPTH; i++) begin
                pipe[i] <= '0;
            end
        end else begin
            pipe[0] <= i_din;
            for (int i = 1; i < DEPTH; i++) begin
                pipe[i] <= pipe[i-1];  // shift toward the output
            end
        end
    end

    assign o_dout = pipe[DEPTH-1];  // exactly DEPTH cycles old

endmodule

// ==== source/fp_add.sv ====
`timescale 1ns/1ps

module fp_add (
    input  logic                i_clk,
    input  logic                i_rst,
    input  logic                i_valid,
    input  fp_pe_pkg::fp_word_t i_a,
    input  fp_pe_pkg::fp_word_t i_b,
    output logic                o_valid,
    output fp_pe_pkg::fp_word_t o_res
);
    import fp_pe_pkg::*;

    // stage 1 input side
    logic [23:0]       a_man;   // with hidden bit, 0 when exp is 0
    logic [23:0]       b_man;
    logic              a_ge_b;  // |a| >= |b|
    // stage 1, ordered operands
    logic              s1_valid;
    logic              s1_sign;  // sign of the larger
    logic              s1_sub;   // signs differ
    logic [7:0]        s1_exp;   // exponent of the larger
    logic [23:0]       s1_man_l;
    logic [23:0]       s1_man_s;
    logic [7:0]        s1_diff;
    // stage 2, aligned sum
    logic [23:0]       shifted;
    logic              s2_valid;
    logic              s2_sign;
    logic [7:0]        s2_exp;
    logic [24:0]       s2_sum;   // bit 24 is the carry
    // stage 3, leading zero count
    logic              s3_valid;
    logic              s3_sign;
    logic [7:0]        s3_exp;
    logic [24:0]       s3_sum;
    logic [4:0]        s3_lz;
    // stage 4 input
    logic [24:0]       norm;
    logic signed [9:0] n_exp;
    fp_word_t          res_next;

    // leading zeros of a 25 bit value, 25 when all clear
    function automatic logic [4:0] clz25(input logic [24:0] v);
        logic [4:0] n;
        logic       found;
        n     = 5'd25;
        found = 1'b0;
        for (int i = 24; i >= 0; i--) begin
            if (!found && v[i]) begin
                n     = 5'(24 - i);
                found = 1'b1;
            end
        end
        return n;
    endfunction

    always_comb begin
        a_man  = (i_a.f.exp == 8'd0) ? 24'd0 : {1'b1, i_a.f.man};  // exp 0 is zero
        b_man  = (i_b.f.exp == 8'd0) ? 24'd0 : {1'b1, i_b.f.man};
        a_ge_b = {i_a.f.exp, a_man} >= {i_b.f.exp, b_man};      // magnitude compare
    end

    always_comb begin
        shifted = s1_man_s >> s1_diff;  // dropped bits are the truncation
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
            s3_valid <= 1'b0;
            o_valid  <= 1'b0;
        end else begin
            s1_valid <= i_valid;
            s2_valid <= s1_valid;
            s3_valid <= s2_valid;
            o_valid  <= s3_valid;
        end
    end

    always_ff @(posedge i_clk) begin
        // stage 1, larger operand goes on the l side
        s1_sign  <= a_ge_b ? i_a.f.sign : i_b.f.sign;
        s1_sub   <= i_a.f.sign ^ i_b.f.sign;
        s1_exp   <= a_ge_b ? i_a.f.exp : i_b.f.exp;
        s1_man_l <= a_ge_b ? a_man : b_man;
        s1_man_s <= a_ge_b ? b_man : a_man;
        s1_diff  <= a_ge_b ? (i_a.f.exp - i_b.f.exp) : (i_b.f.exp - i_a.f.exp);
        // stage 2, l >= s so the difference never goes negative
        s2_sign  <= s1_sign;
        s2_exp   <= s1_exp;
        s2_sum   <= s1_sub ? ({1'b0, s1_man_l} - {1'b0, shifted})
                           : ({1'b0, s1_man_l} + {1'b0, shifted});
        // stage 3
        s3_sign  <= s2_sign;
        s3_exp   <= s2_exp;
        s3_sum   <= s2_sum;
        s3_lz    <= clz25(s2_sum);
        // stage 4
        o_res    <= res_next;
    end

    // leading one to bit 24, then bits 23:1 are the fraction
    always_comb begin
        norm  = s3_sum << s3_lz;
        n_exp = $signed({2'b00, s3_exp}) + 10'sd1 - $signed({5'b00000, s3_lz});
        res_next.f.sign = s3_sign;
        res_next.f.exp  = n_exp[7:0];
        res_next.f.man  = norm[23:1];
        if (s3_sum == 25'd0) begin
            res_next.raw = '0;       // exact cancellation gives +0
        end else if (n_exp <= 10'sd0) begin
            res_next.raw = '0;       // underflow flush
        end else if (n_exp >= 10'sd255) begin
            res_next.f.exp = 8'hff;  // inf with sign of the larger
            res_next.f.man = '0;
        end
    end

endmodule

// ==== source/fp_mul.sv ====
`timescale 1ns/1ps

module fp_mul (
    input  logic                i_clk,
    input  logic                i_rst,
    input  logic                i_valid,
    input  fp_pe_pkg::fp_word_t i_a,
    input  fp_pe_pkg::fp_word_t i_b,
    output logic                o_valid,
    output fp_pe_pkg::fp_word_t o_res
);
    import fp_pe_pkg::*;

    // stage 1, unpacked operands
    logic              s1_valid;
    logic              s1_sign;
    logic              s1_zero;  // either operand has exp 0
    logic signed [9:0] s1_exp;   // ea + eb - bias, may be out of range
    logic [23:0]       s1_ma;
    logic [23:0]       s1_mb;
    // stage 2, raw product
    logic              s2_valid;
    logic              s2_sign;
    logic              s2_zero;
    logic signed [9:0] s2_exp;
    logic [47:0]       s2_prod;  // 1.x * 1.x lands in [1, 4)
    // stage 3 input
    logic signed [9:0] n_exp;
    logic [22:0]       n_man;
    fp_word_t          res_next;

    // valid marks data only, never stalls
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
            o_valid  <= 1'b0;
        end else begin
            s1_valid <= i_valid;
            s2_valid <= s1_valid;
            o_valid  <= s2_valid;
        end
    end

    always_ff @(posedge i_clk) begin
        s1_sign <= i_a.f.sign ^ i_b.f.sign;
        s1_zero <= (i_a.f.exp == 8'd0) || (i_b.f.exp == 8'd0);
        s1_exp  <= $signed({2'b00, i_a.f.exp}) + $signed({2'b00, i_b.f.exp})
                   - 10'(FP_EXP_BIAS);
        s1_ma   <= {1'b1, i_a.f.man};  // hidden bit back on
        s1_mb   <= {1'b1, i_b.f.man};
        s2_sign <= s1_sign;
        s2_zero <= s1_zero;
        s2_exp  <= s1_exp;
        s2_prod <= {24'd0, s1_ma} * {24'd0, s1_mb};  // full 48 bit product
        o_res   <= res_next;
    end

    // one-place normalize, truncate, then range checks
    always_comb begin
        if (s2_prod[47]) begin
            n_man = s2_prod[46:24];  // product >= 2
            n_exp = s2_exp + 10'sd1;
        end else begin
            n_man = s2_prod[45:23];
            n_exp = s2_exp;
        end
        res_next.f.sign = s2_sign;
        res_next.f.exp  = n_exp[7:0];
        res_next.f.man  = n_man;
        if (s2_zero || (n_exp <= 10'sd0)) begin
            res_next.raw = '0;  // zero operand or underflow, +0
        end else if (n_exp >= 10'sd255) begin
            res_next.f.exp = 8'hff;  // inf, sign kept
            res_next.f.man = '0;
        end
    end

endmodule

// ==== source/fp_pe.sv ====
`timescale 1ns/1ps
`include "fp_pe_config.svh"

module fp_pe (
    input  logic                i_clk,
    input  logic                i_rst,
    input  fp_pe_pkg::fp_word_t i_inp1,    // stream a
    input  fp_pe_pkg::fp_word_t i_inp2,    // stream b
    input  fp_pe_pkg::fp_word_t i_inp3,    // broadcast scalar, no strobe
    input  logic                i_valid1,
    input  logic                i_valid2,
    input  logic                i_last1,
    input  logic                i_last2,
    input  fp_pe_pkg::pe_op_e   i_op,      // may change every item
    output fp_pe_pkg::fp_word_t o_out,
    output logic                o_valid,
    output logic                o_last
);
    import fp_pe_pkg::*;

    localparam int W      = `FP_WIDTH;
    localparam int GRP1_W = 3 + 4 + 3 * W;      // op, four strobes, three operands
    localparam int GRP2_W = 3 + 3 + 1 + 2 * W;  // op, strobes, mul valid, product, inp1

    // multiplier side
    logic       mul_vin;
    logic       mul_valid;
    fp_word_t   mul_res;
    // aligned to the adder input
    logic [2:0] op_d_bits;
    pe_op_e     op_d;
    logic       valid1_d;
    logic       valid2_d;
    logic       last1_d;
    logic       last2_d;
    fp_word_t   inp1_d;
    fp_word_t   inp2_d;
    fp_word_t   inp3_d;
    // adder side
    logic       add_vin;
    fp_word_t   add_a;
    fp_word_t   add_b;
    logic       add_valid;
    fp_word_t   add_res;
    // aligned to the output
    logic [2:0] op_dd_bits;
    pe_op_e     op_dd;
    logic       valid1_dd;
    logic       last1_dd;
    logic       last2_dd;
    logic       mul_valid_dd;
    fp_word_t   mul_res_dd;
    fp_word_t   inp1_dd;

    // multiplier only marks items for mul and macc
    assign mul_vin = i_valid1 && i_valid2 && ((i_op == OP_MUL) || (i_op == OP_MACC));

    fp_mul u_mul (
        .i_clk   (i_clk),
        .i_rst   (i_rst),
        .i_valid (mul_vin),
        .i_a     (i_inp1),
        .i_b     (i_inp2),
        .o_valid (mul_valid),
        .o_res   (mul_res)
    );

    // operands, op and strobes ride alongside the multiplier
    delay_line #(
        .WIDTH (GRP1_W),
        .DEPTH (`FP_MUL_LAT)
    ) u_align_mul (
        .i_clk  (i_clk),
        .i_rst  (i_rst),
        .i_din  ({i_op, i_valid1, i_valid2, i_last1, i_last2, i_inp1, i_inp2, i_inp3}),
        .o_dout ({op_d_bits, valid1_d, valid2_d, last1_d, last2_d, inp1_d, inp2_d, inp3_d})
    );

    assign op_d = pe_op_e'(op_d_bits);

    // adder operands per delayed op
    always_comb begin
        if (op_d == OP_MACC) begin
            add_a   = mul_res;    // product lands here this cycle
            add_b   = inp3_d;     // c of the same item
            add_vin = mul_valid;  // already has the and rule
        end else begin
            add_a   = inp1_d;
            add_b   = inp2_d;
            add_vin = (op_d == OP_ADD) && valid1_d && valid2_d;
        end
    end

    fp_add u_add (
        .i_clk   (i_clk),
        .i_rst   (i_rst),
        .i_valid (add_vin),
        .i_a     (add_a),
        .i_b     (add_b),
        .o_valid (add_valid),
        .o_res   (add_res)
    );

    // product, inp1, op and strobes wait out the adder
    delay_line #(
        .WIDTH (GRP2_W),
        .DEPTH (`FP_ADD_LAT)
    ) u_align_add (
        .i_clk  (i_clk),
        .i_rst  (i_rst),
        .i_din  ({op_d_bits, valid1_d, last1_d, last2_d, mul_valid, mul_res, inp1_d}),
        .o_dout ({op_dd_bits, valid1_dd, last1_dd, last2_dd, mul_valid_dd, mul_res_dd,
                  inp1_dd})
    );

    assign op_dd = pe_op_e'(op_dd_bits);

    // output select on the op that came with the item
    always_comb begin
        case (op_dd)
            OP_ADD, OP_MACC: begin
                o_out   = add_res;
                o_valid = add_valid;
                o_last  = add_valid && (last1_dd || last2_dd);
            end
            OP_MUL: begin
                o_out   = mul_res_dd;
                o_valid = mul_valid_dd;
                o_last  = mul_valid_dd && (last1_dd || last2_dd);
            end
            default: begin  // acc, nop, 5..7
                o_out   = inp1_dd;
                o_valid = valid1_dd;
                o_last  = valid1_dd && last1_dd;
            end
        endcase
    end

endmodule

// ==== source/fp_pe_config.svh ====
`ifndef FP_PE_CONFIG_SVH
`define FP_PE_CONFIG_SVH

// binary32 word
`define FP_WIDTH 32

// register stages in fp_mul
`define FP_MUL_LAT 3

// register stages in fp_add
`define FP_ADD_LAT 4

// item to result, same for every opcode
`define FP_PE_LAT (`FP_MUL_LAT + `FP_ADD_LAT)

`endif

// ==== source/fp_pe_pkg.sv ====
`include "fp_pe_config.svh"

package fp_pe_pkg;

    // binary32 exponent bias, shared by mul and add
    localparam int FP_EXP_BIAS = 127;

    // per-item opcode, 5..7 undefined and passed through like nop
    typedef enum logic [2:0] {
        OP_ADD  = 3'd0,  // a + b
        OP_ACC  = 3'd1,  // reserved, acts as pass-through
        OP_MUL  = 3'd2,  // a * b
        OP_MACC = 3'd3,  // a * b + c
        OP_NOP  = 3'd4   // pass a
    } pe_op_e;

    // binary32 fields, msb first
    typedef struct packed {
        logic        sign;
        logic [7:0]  exp;  // biased exponent, 0 means zero here
        logic [22:0] man;  // fraction without hidden bit
    } fp_fields_t;

    // same word, moved raw or taken apart into fields
    typedef union packed {
        logic [`FP_WIDTH-1:0] raw;
        fp_fields_t           f;
    } fp_word_t;

endpackage

// ==== tb.f ====
+incdir+source
source/fp_pe_pkg.sv
source/delay_line.sv
source/fp_mul.sv
source/fp_add.sv
source/fp_pe.sv
sim/fp_pe_assert.sv
sim/fp_pe_tb.sv
